//--- src/isa_pkg.sv
package isa_pkg;

    // machine word and register file geometry
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    // decoded operation, numbering shared with the stimulus file
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LD   = 4'd7
    } opcode_e;

    // load memory, word addressed, address wraps
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);
    // word a holds a * LOAD_HASH
    localparam word_t LOAD_HASH = 32'h9E3779B1;
    // result registers between the memory read and wb_load
    localparam int LOAD_LAG = 2;

    // ops that finish in one cycle and write back on the ALU port
    function automatic logic is_alu(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};
    endfunction

endpackage

//--- src/pipe_pkg.sv
package pipe_pkg;

    // decoded instruction at the issue port
    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::opcode_e  op;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rj;
        isa_pkg::reg_idx_t rk;
        isa_pkg::word_t    imm;
    } issue_t;

    // register-read output, instruction plus both source values
    typedef struct packed {
        isa_pkg::word_t    pc;
        isa_pkg::opcode_e  op;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rj;
        isa_pkg::reg_idx_t rk;
        isa_pkg::word_t    imm;
        isa_pkg::word_t    rj_data;
        isa_pkg::word_t    rk_data;
    } operand_t;

    // one register write, also what the checker sees
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    data;
    } wb_t;

endpackage

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              aresetn,
    input  pipe_pkg::wb_t     wa,
    input  pipe_pkg::wb_t     wb,
    input  isa_pkg::reg_idx_t raddr_j,
    input  isa_pkg::reg_idx_t raddr_k,
    output logic [31:0]       rdata_j,
    output logic [31:0]       rdata_k
);

    // r0 has no storage
    isa_pkg::word_t regs [1:isa_pkg::NUM_REGS-1];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 1; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wa.valid && wa.rd != '0) begin
                regs[wa.rd] <= wa.data;
            end
            // later write wins, port wb has priority
            if (wb.valid && wb.rd != '0) begin
                regs[wb.rd] <= wb.data;
            end
        end
    end

    // write-first read, same priority as the write side
    always_comb begin
        if (raddr_j == '0) begin
            rdata_j = '0;
        end else if (wb.valid && wb.rd == raddr_j) begin
            rdata_j = wb.data;
        end else if (wa.valid && wa.rd == raddr_j) begin
            rdata_j = wa.data;
        end else begin
            rdata_j = regs[raddr_j];
        end
    end

    always_comb begin
        if (raddr_k == '0) begin
            rdata_k = '0;
        end else if (wb.valid && wb.rd == raddr_k) begin
            rdata_k = wb.data;
        end else if (wa.valid && wa.rd == raddr_k) begin
            rdata_k = wa.data;
        end else begin
            rdata_k = regs[raddr_k];
        end
    end

    // load-use stall keeps a load and an ALU op off one register at once
    a_no_dual_write: assert property (@(posedge clk) disable iff (!aresetn)
        !(wa.valid && wb.valid && wa.rd == wb.rd && wa.rd != '0));

endmodule

//--- src/load_hazard.sv
`timescale 1ns/1ps

module load_hazard (
    input  logic              clk,
    input  logic              aresetn,
    input  isa_pkg::reg_idx_t ex_load_rd,
    input  logic              ex_load_leaving,
    input  isa_pkg::reg_idx_t src_j,
    input  isa_pkg::reg_idx_t src_k,
    input  isa_pkg::reg_idx_t dst,
    output logic              stall
);

    // rd of loads that already left execute, index 0 youngest
    isa_pkg::reg_idx_t hist [isa_pkg::LOAD_LAG];
    // execute slot first, then the history
    isa_pkg::reg_idx_t pending [isa_pkg::LOAD_LAG+1];
    // load in execute targets a register an older load still owns
    logic              ex_rd_in_hist;

    // shifts every cycle, zero means no load
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < isa_pkg::LOAD_LAG; i++) begin
                hist[i] <= '0;
            end
        end else begin
            hist[0] <= ex_load_leaving ? ex_load_rd : '0;
            for (int i = 1; i < isa_pkg::LOAD_LAG; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    always_comb begin
        // ex_load_rd is zero unless a load sits in execute
        pending[0] = ex_load_rd;
        for (int i = 0; i < isa_pkg::LOAD_LAG; i++) begin
            pending[i+1] = hist[i];
        end
    end

    // sources and rd both checked, rd keeps writes in program order
    always_comb begin
        stall = 1'b0;
        for (int i = 0; i <= isa_pkg::LOAD_LAG; i++) begin
            if (pending[i] != '0 &&
                (pending[i] == src_j || pending[i] == src_k || pending[i] == dst)) begin
                stall = 1'b1;
            end
        end
    end

    always_comb begin
        ex_rd_in_hist = 1'b0;
        for (int i = 0; i < isa_pkg::LOAD_LAG; i++) begin
            if (hist[i] == ex_load_rd) begin
                ex_rd_in_hist = 1'b1;
            end
        end
    end

    // the rd stall keeps two loads to one register from overlapping
    a_no_double_pending: assert property (@(posedge clk) disable iff (!aresetn)
        (ex_load_rd != '0) |-> !ex_rd_in_hist);

endmodule

//--- src/reg_read_stage.sv
`timescale 1ns/1ps

module reg_read_stage (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               issue_valid,
    input  pipe_pkg::issue_t   issue,
    output logic               issue_ready,
    input  pipe_pkg::wb_t      wa,
    input  pipe_pkg::wb_t      wb,
    input  isa_pkg::reg_idx_t  ex_load_rd,
    input  logic               ex_load_leaving,
    output logic               opnd_valid,
    output pipe_pkg::operand_t opnd,
    input  logic               ex_allowin
);

    logic [31:0] rdata_j;
    logic [31:0] rdata_k;
    logic        stall;
    logic        issue_fire;
    logic        run_q;

    // operands read straight from the waiting bundle
    regfile u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .wa      (wa),
        .wb      (wb),
        .raddr_j (issue.rj),
        .raddr_k (issue.rk),
        .rdata_j (rdata_j),
        .rdata_k (rdata_k)
    );

    load_hazard u_load_hazard (
        .clk             (clk),
        .aresetn         (aresetn),
        .ex_load_rd      (ex_load_rd),
        .ex_load_leaving (ex_load_leaving),
        .src_j           (issue.rj),
        .src_k           (issue.rk),
        .dst             (issue.rd),
        .stall           (stall)
    );

    // ready stays low until the first cycle after reset
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // slot is free when empty or when execute drains it this cycle
    assign issue_ready = run_q && !stall && (ex_allowin || !opnd_valid);
    assign issue_fire  = issue_valid && issue_ready;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            opnd_valid <= 1'b0;
        end else if (issue_fire) begin
            opnd_valid <= 1'b1;
        end else if (ex_allowin) begin
            // drained with nothing behind it
            opnd_valid <= 1'b0;
        end
    end

    // payload only moves on a transfer, otherwise holds
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            opnd <= '{pc: issue.pc, op: issue.op, rd: issue.rd, rj: issue.rj,
                      rk: issue.rk, imm: issue.imm, rj_data: rdata_j, rk_data: rdata_k};
        end
    end

    // a blocked instruction is neither lost nor changed
    a_opnd_hold: assert property (@(posedge clk) disable iff (!aresetn)
        (opnd_valid && !ex_allowin) |=> (opnd_valid && $stable(opnd)));

endmodule

//--- src/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               opnd_valid,
    input  pipe_pkg::operand_t opnd,
    output logic               ex_allowin,
    input  logic               mem_ready,
    output isa_pkg::reg_idx_t  ex_load_rd,
    output logic               ex_load_leaving,
    output pipe_pkg::wb_t      wb_alu,
    output pipe_pkg::wb_t      wb_load
);

    // read-only load memory
    isa_pkg::word_t dmem [isa_pkg::DMEM_WORDS];
    // memory read stage at 0, then the lag registers
    pipe_pkg::wb_t  ld_pipe [isa_pkg::LOAD_LAG+1];

    logic                        is_load;
    isa_pkg::word_t              ld_sum;
    logic [isa_pkg::DMEM_AW-1:0] ld_addr;
    isa_pkg::word_t              alu_res;

    assign is_load = opnd_valid && opnd.op == isa_pkg::OP_LD;

    // only a load without memory grant blocks the stage
    assign ex_allowin      = !(is_load && !mem_ready);
    assign ex_load_leaving = is_load && mem_ready;
    // zero when no load is in execute
    assign ex_load_rd      = is_load ? opnd.rd : '0;

    always_comb begin
        case (opnd.op)
            isa_pkg::OP_ADD:  alu_res = opnd.rj_data + opnd.rk_data;
            isa_pkg::OP_SUB:  alu_res = opnd.rj_data - opnd.rk_data;
            isa_pkg::OP_AND:  alu_res = opnd.rj_data & opnd.rk_data;
            isa_pkg::OP_OR:   alu_res = opnd.rj_data | opnd.rk_data;
            isa_pkg::OP_XOR:  alu_res = opnd.rj_data ^ opnd.rk_data;
            isa_pkg::OP_ADDI: alu_res = opnd.rj_data + opnd.imm;
            default:          alu_res = '0;
        endcase
    end

    // same-cycle writeback, nop and r0 writes dropped
    assign wb_alu = '{valid: opnd_valid && isa_pkg::is_alu(opnd.op) && opnd.rd != '0,
                      pc: opnd.pc, rd: opnd.rd, data: alu_res};

    // word address wraps over the memory depth
    assign ld_sum  = opnd.rj_data + opnd.imm;
    assign ld_addr = ld_sum[isa_pkg::DMEM_AW-1:0];

    // hashed contents loaded at reset, never written after
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int a = 0; a < isa_pkg::DMEM_WORDS; a++) begin
                dmem[a] <= isa_pkg::word_t'(a) * isa_pkg::LOAD_HASH;
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i <= isa_pkg::LOAD_LAG; i++) begin
                ld_pipe[i] <= '0;
            end
        end else begin
            // synchronous read as the load leaves, r0 loads retire silently
            ld_pipe[0] <= '{valid: ex_load_leaving && opnd.rd != '0,
                            pc: opnd.pc, rd: opnd.rd, data: dmem[ld_addr]};
            for (int i = 1; i <= isa_pkg::LOAD_LAG; i++) begin
                ld_pipe[i] <= ld_pipe[i-1];
            end
        end
    end

    // valid in the third cycle after leaving, after the history clears
    assign wb_load = ld_pipe[isa_pkg::LOAD_LAG];

endmodule

//--- src/rr_core_top.sv
`timescale 1ns/1ps

module rr_core_top (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             issue_valid,
    input  pipe_pkg::issue_t issue,
    output logic             issue_ready,
    input  logic             mem_ready,
    output pipe_pkg::wb_t    wb_alu,
    output pipe_pkg::wb_t    wb_load
);

    pipe_pkg::operand_t opnd;
    logic               opnd_valid;
    logic               ex_allowin;
    isa_pkg::reg_idx_t  ex_load_rd;
    logic               ex_load_leaving;

    // both writeback ports loop back into the register file
    reg_read_stage u_reg_read_stage (
        .clk             (clk),
        .aresetn         (aresetn),
        .issue_valid     (issue_valid),
        .issue           (issue),
        .issue_ready     (issue_ready),
        .wa              (wb_alu),
        .wb              (wb_load),
        .ex_load_rd      (ex_load_rd),
        .ex_load_leaving (ex_load_leaving),
        .opnd_valid      (opnd_valid),
        .opnd            (opnd),
        .ex_allowin      (ex_allowin)
    );

    exec_stage u_exec_stage (
        .clk             (clk),
        .aresetn         (aresetn),
        .opnd_valid      (opnd_valid),
        .opnd            (opnd),
        .ex_allowin      (ex_allowin),
        .mem_ready       (mem_ready),
        .ex_load_rd      (ex_load_rd),
        .ex_load_leaving (ex_load_leaving),
        .wb_alu          (wb_alu),
        .wb_load         (wb_load)
    );

endmodule

//--- bench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic          clk,
    input  logic          aresetn,
    input  logic          issue_ready,
    input  pipe_pkg::wb_t wb_alu,
    input  pipe_pkg::wb_t wb_load,
    output int            errors,
    output int            expected_total,
    output int            seen_total
);

    localparam int MAX_LINES = 32;
    localparam int COLS      = 7;

    logic [31:0]       stim [MAX_LINES*COLS];
    // expected writebacks keyed by pc
    isa_pkg::word_t    exp_data [logic [31:0]];
    isa_pkg::reg_idx_t exp_rd   [logic [31:0]];
    logic              exp_load [logic [31:0]];
    int                seen     [logic [31:0]];
    int                err_count = 0;
    int                seen_count = 0;
    logic              first_run_cycle = 1'b1;

    assign errors     = err_count;
    assign seen_total = seen_count;

    initial begin
        logic [31:0]       pc;
        isa_pkg::opcode_e  op;
        isa_pkg::reg_idx_t rd;
        expected_total = 0;
        for (int i = 0; i < MAX_LINES*COLS; i++) begin
            stim[i] = '1;
        end
        $readmemh("bench/rr_stimulus.txt", stim);
        for (int n = 0; n < MAX_LINES; n++) begin
            pc = stim[n*COLS];
            if (pc == 32'hffffffff) begin
                break;
            end
            op = isa_pkg::opcode_e'(stim[n*COLS+1][3:0]);
            rd = stim[n*COLS+2][4:0];
            // nop lines and r0 destinations never reach a write port
            if (op != isa_pkg::OP_NOP && rd != '0) begin
                exp_data[pc] = stim[n*COLS+6];
                exp_rd[pc]   = rd;
                exp_load[pc] = (op == isa_pkg::OP_LD);
                seen[pc]     = 0;
                expected_total++;
            end
        end
    end

    task automatic expect_low(input logic value, input string name);
        if (value !== 1'b0) begin
            $display("Error at %0t ns: %s is %b, expected 0", $time, name, value);
            err_count++;
        end
    endtask

    task automatic check_wb(input pipe_pkg::wb_t w, input string port, input logic load_port);
        if (w.valid) begin
            if (!exp_data.exists(w.pc)) begin
                $display("%s wrote back pc %h at %0t ns, but that pc should never write back",
                         port, w.pc, $time);
                err_count++;
            end else begin
                if (seen[w.pc] != 0) begin
                    $display("pc %h wrote back a second time at %0t ns on %s", w.pc, $time, port);
                    err_count++;
                end else begin
                    seen_count++;
                end
                seen[w.pc]++;
                // loads belong on wb_load, ALU ops on wb_alu
                if (exp_load[w.pc] != load_port) begin
                    $display("pc %h wrote back on the wrong port %s at %0t ns", w.pc, port, $time);
                    err_count++;
                end
                if (w.rd !== exp_rd[w.pc]) begin
                    $display("Error at %0t ns: %s.rd for pc %h is %0d, expected %0d",
                             $time, port, w.pc, w.rd, exp_rd[w.pc]);
                    err_count++;
                end
                if (w.data !== exp_data[w.pc]) begin
                    $display("Error at %0t ns: %s.data for pc %h is %h, expected %h",
                             $time, port, w.pc, w.data, exp_data[w.pc]);
                    err_count++;
                end
            end
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!aresetn) begin
            expect_low(issue_ready, "issue_ready");
            expect_low(wb_alu.valid, "wb_alu.valid");
            expect_low(wb_load.valid, "wb_load.valid");
            first_run_cycle = 1'b1;
        end else begin
            // ready only comes up one cycle after release
            if (first_run_cycle) begin
                expect_low(issue_ready, "issue_ready");
                first_run_cycle = 1'b0;
            end
            check_wb(wb_alu, "wb_alu", 1'b0);
            check_wb(wb_load, "wb_load", 1'b1);
        end
    end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int MAX_LINES     = 32;
    localparam int COLS          = 7;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 400;

    logic             clk = 1'b0;
    logic             aresetn;
    logic             issue_valid;
    pipe_pkg::issue_t issue;
    logic             issue_ready;
    logic             mem_ready = 1'b0;
    pipe_pkg::wb_t    wb_alu;
    pipe_pkg::wb_t    wb_load;

    // flat copy of the stimulus file, seven words per line
    logic [31:0] stim [MAX_LINES*COLS];
    int          mem_left = 0;
    int          timeouts = 0;
    int          chk_errors;
    int          chk_expected;
    int          chk_seen;

    // 8 ns period
    always #4 clk = ~clk;

    rr_core_top uut (
        .clk         (clk),
        .aresetn     (aresetn),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .mem_ready   (mem_ready),
        .wb_alu      (wb_alu),
        .wb_load     (wb_load)
    );

    tb_checker chk (
        .clk            (clk),
        .aresetn        (aresetn),
        .issue_ready    (issue_ready),
        .wb_alu         (wb_alu),
        .wb_load        (wb_load),
        .errors         (chk_errors),
        .expected_total (chk_expected),
        .seen_total     (chk_seen)
    );

    // memory grant, long low stretches and short high bursts
    always @(posedge clk) begin
        if (!aresetn) begin
            mem_ready <= 1'b0;
            mem_left  <= 0;
        end else if (mem_left == 0) begin
            mem_ready <= !mem_ready;
            // current value is the old one, pick the length of the next stretch
            if (mem_ready) begin
                mem_left <= 3 + $urandom_range(11);
            end else begin
                mem_left <= 1 + $urandom_range(2);
            end
        end else begin
            mem_left <= mem_left - 1;
        end
    end

    // one file line into an issue bundle
    function automatic pipe_pkg::issue_t bundle_at(input int n);
        pipe_pkg::issue_t b;
        b.pc  = stim[n*COLS];
        b.op  = isa_pkg::opcode_e'(stim[n*COLS+1][3:0]);
        b.rd  = stim[n*COLS+2][4:0];
        b.rj  = stim[n*COLS+3][4:0];
        b.rk  = stim[n*COLS+4][4:0];
        b.imm = stim[n*COLS+5];
        return b;
    endfunction

    // hold the bundle until an edge with ready high
    task automatic send_bundle(input pipe_pkg::issue_t b);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        issue_valid <= 1'b1;
        issue       <= b;
        while (!taken && waited < READY_TIMEOUT) begin
            // ready sampled mid-cycle, it only moves after rising edges
            @(negedge clk);
            taken = issue_ready;
            @(posedge clk);
            waited++;
        end
        if (!taken) begin
            $display("issue_ready never rose for pc %h within %0d cycles", b.pc, READY_TIMEOUT);
            timeouts++;
        end
    endtask

    initial begin
        int waited;
        void'($urandom(32'h31334f03));
        aresetn     = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        for (int i = 0; i < MAX_LINES*COLS; i++) begin
            stim[i] = '1;
        end
        $readmemh("bench/rr_stimulus.txt", stim);
        repeat (8) @(posedge clk);
        aresetn <= 1'b1;
        for (int n = 0; n < MAX_LINES && timeouts == 0; n++) begin
            // all-ones pc ends the list
            if (stim[n*COLS] == 32'hffffffff) begin
                break;
            end
            send_bundle(bundle_at(n));
            // random bubble on the issue port
            if ($urandom_range(3) == 0) begin
                issue_valid <= 1'b0;
                @(posedge clk);
            end
        end
        issue_valid <= 1'b0;
        waited = 0;
        while (chk_seen < chk_expected && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (chk_seen < chk_expected) begin
            $display("%0d of %0d expected writebacks never appeared",
                     chk_expected - chk_seen, chk_expected);
            timeouts++;
        end
        // late duplicates or strays still get caught
        repeat (16) @(posedge clk);
        $display("errors: %0d, timeouts: %0d, writebacks seen: %0d of %0d",
                 chk_errors, timeouts, chk_seen, chk_expected);
        if (chk_errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- bench/rr_stimulus.txt
// columns in hex: pc opcode rd rj rk imm expected, opcode numbering as in isa_pkg
// expected is the value written to rd, ignored for nop and r0; pc ffffffff ends the list
00001000 6 01 00 00 00000005 00000005
00001004 6 02 01 00 00000003 00000008
00001008 1 03 01 02 00000000 0000000d
0000100c 2 04 01 02 00000000 fffffffd
00001010 3 05 04 03 00000000 0000000d
00001014 5 06 03 04 00000000 fffffff0
00001018 4 07 01 02 00000000 0000000d
0000101c 7 08 01 00 00000002 538453d7
00001020 1 09 08 01 00000000 538453dc
00001024 7 0a 02 00 0000003c 78dde6c4
00001028 6 0a 00 00 00000077 00000077
0000102c 5 0b 0a 09 00000000 538453ab
00001030 0 00 00 00 00000000 00000000
00001034 1 00 01 02 00000000 00000000
00001038 7 0c 00 00 00000025 de049695
0000103c 7 0d 0c 00 00000001 98c47536
00001040 7 0e 0d 00 00000000 5fb3ab56
00001044 2 0f 0e 08 00000000 0c2f577f
00001048 6 01 01 00 ffffffff 00000004
0000104c 3 10 0f 0a 00000000 00000077
ffffffff 0 00 00 00 00000000 00000000

//--- list.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/regfile.sv
src/load_hazard.sv
src/reg_read_stage.sv
src/exec_stage.sv
src/rr_core_top.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_top -f list.f -o tb_sim > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log && grep -qx '>>> PASS' sim.log || exit 1
